// ==== design/ex_alu.sv ====
// Combinational 64-bit ALU; shifts use opb[5:0] only, undefined codes give ALU_ILLEGAL_RESULT
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output ex_pkg::word_t     result
);

  localparam int MSB = ex_pkg::WORD_W - 1;

  logic lt_signed;
  logic lt_unsigned;
  logic equal;

  // Signed less-than from the sign bits
  function automatic logic signed_lt(input ex_pkg::word_t a, input ex_pkg::word_t b);
    if (a[MSB] == b[MSB])
      return a < b;
    else
      return a[MSB];
  endfunction

  // Shared compare terms
  assign lt_signed   = signed_lt(opa, opb);
  assign lt_unsigned = opa < opb;
  assign equal       = opa == opb;

  always_comb
  begin
    case (func)
      ex_pkg::ALU_ADDQ:   result = opa + opb;
      ex_pkg::ALU_SUBQ:   result = opa - opb;
      ex_pkg::ALU_AND:    result = opa & opb;
      ex_pkg::ALU_BIC:    result = opa & ~opb;
      ex_pkg::ALU_BIS:    result = opa | opb;
      ex_pkg::ALU_ORNOT:  result = opa | ~opb;
      ex_pkg::ALU_XOR:    result = opa ^ opb;
      ex_pkg::ALU_EQV:    result = opa ^ ~opb;
      // Shift amount is the low six bits
      ex_pkg::ALU_SRL:    result = opa >> opb[5:0];
      ex_pkg::ALU_SLL:    result = opa << opb[5:0];
      ex_pkg::ALU_SRA:    result = $signed(opa) >>> opb[5:0];
      // Compares return 0 or 1 in bit 0
      ex_pkg::ALU_CMPULT: result = {{MSB{1'b0}}, lt_unsigned};
      ex_pkg::ALU_CMPEQ:  result = {{MSB{1'b0}}, equal};
      ex_pkg::ALU_CMPULE: result = {{MSB{1'b0}}, lt_unsigned | equal};
      ex_pkg::ALU_CMPLT:  result = {{MSB{1'b0}}, lt_signed};
      ex_pkg::ALU_CMPLE:  result = {{MSB{1'b0}}, lt_signed | equal};
      default:            result = ex_pkg::ALU_ILLEGAL_RESULT;
    endcase
  end

endmodule

// ==== design/ex_arbiter.sv ====
// Combinational per-lane merge; a completing multiply always wins and stalls the integer path
`timescale 1ns/1ps

module ex_arbiter (
  ex_result_if.dst         int_in,
  ex_result_if.dst         mult_in,
  output logic             stall,
  output ex_pkg::inst_t    ir,
  output ex_pkg::word_t    npc,
  output ex_pkg::reg_idx_t dest_reg,
  output ex_pkg::word_t    result,
  output logic             valid
);

  always_comb
  begin
    if (mult_in.valid)
    begin
      // Multiplier cannot wait, integer result stays in its register
      ir       = mult_in.ir;
      npc      = mult_in.npc;
      dest_reg = mult_in.dest_reg;
      result   = mult_in.result;
      valid    = 1'b1;
      stall    = 1'b1;
    end
    else
    begin
      ir       = int_in.ir;
      npc      = int_in.npc;
      dest_reg = int_in.dest_reg;
      result   = int_in.result;
      valid    = int_in.valid;
      stall    = 1'b0;
    end
  end

  // Only the multiplier may block the lane
  always_comb
  begin
    a_stall_src: assert final (!stall || mult_in.valid);
  end

endmodule

// ==== design/ex_brcond.sv ====
// Combinational branch test on opa; opb must already be the byte displacement added to npc
`timescale 1ns/1ps

module ex_brcond (
  input  ex_pkg::word_t    opa,
  input  ex_pkg::word_t    opb,
  input  ex_pkg::word_t    npc,
  input  ex_pkg::br_func_t func,
  output logic             taken,
  output ex_pkg::word_t    next_pc
);

  logic cond;
  logic is_neg;
  logic is_zero;

  assign is_neg  = opa[ex_pkg::WORD_W-1];
  assign is_zero = opa == '0;

  // Base condition from the low two bits
  always_comb
  begin
    case (func[1:0])
      2'b00:   cond = ~opa[0];
      2'b01:   cond = is_zero;
      2'b10:   cond = is_neg;
      default: cond = is_neg | is_zero;
    endcase
  end

  // Bit 2 inverts the test
  assign taken = cond ^ func[2];

  // Fall through to npc when not taken
  assign next_pc = taken ? npc + opb : npc;

endmodule

// ==== design/ex_int_lane.sv ====
// Integer path of one lane; valid must be low for multiplies, the register holds while stall is high
`timescale 1ns/1ps

module ex_int_lane #(
  parameter bit BRANCH_EN = 1'b0
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              stall,
  input  logic              valid,
  input  logic              is_branch,
  input  ex_pkg::inst_t     ir,
  input  ex_pkg::word_t     npc,
  input  ex_pkg::reg_idx_t  dest_reg,
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output logic              take_branch,
  ex_result_if.src          out
);

  ex_pkg::word_t    alu_result;
  ex_pkg::word_t    br_target;
  logic             br_taken;
  logic             do_branch;

  // Result register
  logic             valid_q;
  logic             taken_q;
  ex_pkg::inst_t    ir_q;
  ex_pkg::word_t    npc_q;
  ex_pkg::reg_idx_t dest_q;
  ex_pkg::word_t    result_q;

  ex_alu alu (
    .opa    (opa),
    .opb    (opb),
    .func   (func),
    .result (alu_result)
  );

  // Branch logic only on the lane that resolves branches
  if (BRANCH_EN)
  begin : g_branch
    ex_brcond brcond (
      .opa     (opa),
      .opb     (opb),
      .npc     (npc),
      .func    (ex_pkg::br_func_t'(func[2:0])),
      .taken   (br_taken),
      .next_pc (br_target)
    );
  end
  else
  begin : g_no_branch
    assign br_taken  = 1'b0;
    assign br_target = npc;
  end

  assign do_branch = BRANCH_EN && is_branch;

  // Control bits advance only when the lane is free
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid_q <= 1'b0;
      taken_q <= 1'b0;
    end
    else if (!stall)
    begin
      valid_q <= valid;
      taken_q <= valid && do_branch && br_taken;
    end
  end

  // Payload, branches carry the next pc as their result
  always_ff @(posedge clock)
  begin
    if (valid && !stall)
    begin
      ir_q     <= ir;
      npc_q    <= npc;
      dest_q   <= dest_reg;
      result_q <= do_branch ? br_target : alu_result;
    end
  end

  assign out.valid    = valid_q;
  assign out.ir       = ir_q;
  assign out.npc      = npc_q;
  assign out.dest_reg = dest_q;
  assign out.result   = result_q;

  // Taken only shows in the cycle the branch itself is on the bus
  assign take_branch = taken_q && !stall;

  a_func_known: assert property (@(posedge clock) disable iff (reset)
    valid && !stall |-> !$isunknown(func));

endmodule

// ==== design/ex_mult.sv ====
// Pipelined multiplier, product modulo 2^64 after MULT_STAGES cycles; MULT_STAGES must divide 64
`timescale 1ns/1ps

module ex_mult #(
  parameter int MULT_STAGES = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             stall,
  input  logic             valid,
  input  ex_pkg::inst_t    ir,
  input  ex_pkg::word_t    npc,
  input  ex_pkg::reg_idx_t dest_reg,
  input  ex_pkg::word_t    opa,
  input  ex_pkg::word_t    opb,
  ex_result_if.src         out
);

  localparam int SLICE_W = ex_pkg::WORD_W / MULT_STAGES;

  // Chain taps, index 0 is the issue side
  ex_pkg::inst_t        ir_c      [MULT_STAGES+1];
  ex_pkg::word_t        npc_c     [MULT_STAGES+1];
  ex_pkg::reg_idx_t     dest_c    [MULT_STAGES+1];
  ex_pkg::word_t        product_c [MULT_STAGES+1];
  ex_pkg::word_t        mplier_c  [MULT_STAGES+1];
  ex_pkg::word_t        mcand_c   [MULT_STAGES+1];
  logic [MULT_STAGES:0] done_c;
  logic                 start;

  if (ex_pkg::WORD_W % MULT_STAGES != 0)
  begin : g_bad_stages
    $error("MULT_STAGES must divide the word width");
  end

  // No new multiply while the lane is busy
  assign start = valid && !stall;

  assign done_c[0]    = start;
  assign ir_c[0]      = ir;
  assign npc_c[0]     = npc;
  assign dest_c[0]    = dest_reg;
  assign product_c[0] = '0;
  assign mplier_c[0]  = opb;
  assign mcand_c[0]   = opa;

  for (genvar i = 0; i < MULT_STAGES; i++)
  begin : g_stage
    ex_mult_stage #(
      .SLICE_W (SLICE_W)
    ) stage (
      .clock        (clock),
      .reset        (reset),
      .start        (done_c[i]),
      .ir_in        (ir_c[i]),
      .npc_in       (npc_c[i]),
      .dest_reg_in  (dest_c[i]),
      .product_in   (product_c[i]),
      .mplier_in    (mplier_c[i]),
      .mcand_in     (mcand_c[i]),
      .done         (done_c[i+1]),
      .ir_out       (ir_c[i+1]),
      .npc_out      (npc_c[i+1]),
      .dest_reg_out (dest_c[i+1]),
      .product_out  (product_c[i+1]),
      .mplier_out   (mplier_c[i+1]),
      .mcand_out    (mcand_c[i+1])
    );
  end

  assign out.valid    = done_c[MULT_STAGES];
  assign out.ir       = ir_c[MULT_STAGES];
  assign out.npc      = npc_c[MULT_STAGES];
  assign out.dest_reg = dest_c[MULT_STAGES];
  assign out.result   = product_c[MULT_STAGES];

  a_latency: assert property (@(posedge clock) disable iff (reset)
    out.valid |-> $past(start, MULT_STAGES));

endmodule

// ==== design/ex_mult_stage.sv ====
// One multiplier slice; SLICE_W bits of the multiplier per stage, payload registers have no reset
`timescale 1ns/1ps

module ex_mult_stage #(
  parameter int SLICE_W = 16
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  ex_pkg::inst_t    ir_in,
  input  ex_pkg::word_t    npc_in,
  input  ex_pkg::reg_idx_t dest_reg_in,
  input  ex_pkg::word_t    product_in,
  input  ex_pkg::word_t    mplier_in,
  input  ex_pkg::word_t    mcand_in,
  output logic             done,
  output ex_pkg::inst_t    ir_out,
  output ex_pkg::word_t    npc_out,
  output ex_pkg::reg_idx_t dest_reg_out,
  output ex_pkg::word_t    product_out,
  output ex_pkg::word_t    mplier_out,
  output ex_pkg::word_t    mcand_out
);

  ex_pkg::word_t partial;

  // Low slice times the multiplicand, truncated to the word
  assign partial = mplier_in[SLICE_W-1:0] * mcand_in;

  // Accumulate and move on to the next slice
  always_ff @(posedge clock)
  begin
    product_out  <= product_in + partial;
    mplier_out   <= mplier_in >> SLICE_W;
    mcand_out    <= mcand_in << SLICE_W;
    ir_out       <= ir_in;
    npc_out      <= npc_in;
    dest_reg_out <= dest_reg_in;
  end

  // Valid bit travels with the data
  always_ff @(posedge clock)
  begin
    if (reset)
      done <= 1'b0;
    else
      done <= start;
  end

endmodule

// ==== design/ex_pkg.sv ====
// Word, tag and code definitions for the EX stage; ALU code 5'h0b is unassigned and yields ALU_ILLEGAL_RESULT
package ex_pkg;

  // Datapath widths
  localparam int WORD_W    = 64;
  localparam int INST_W    = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [INST_W-1:0]    inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [4:0]           alu_func_t;
  typedef logic [2:0]           br_func_t;

  // ALU function codes
  localparam alu_func_t ALU_ADDQ   = 5'h00;
  localparam alu_func_t ALU_SUBQ   = 5'h01;
  localparam alu_func_t ALU_AND    = 5'h02;
  localparam alu_func_t ALU_BIC    = 5'h03;
  localparam alu_func_t ALU_BIS    = 5'h04;
  localparam alu_func_t ALU_ORNOT  = 5'h05;
  localparam alu_func_t ALU_XOR    = 5'h06;
  localparam alu_func_t ALU_EQV    = 5'h07;
  localparam alu_func_t ALU_SRL    = 5'h08;
  localparam alu_func_t ALU_SLL    = 5'h09;
  localparam alu_func_t ALU_SRA    = 5'h0a;
  // 5'h0b was the multiply slot, multiplies now go to the multiplier pipeline
  localparam alu_func_t ALU_CMPULT = 5'h0c;
  localparam alu_func_t ALU_CMPEQ  = 5'h0d;
  localparam alu_func_t ALU_CMPULE = 5'h0e;
  localparam alu_func_t ALU_CMPLT  = 5'h0f;
  localparam alu_func_t ALU_CMPLE  = 5'h10;

  // Branch conditions, bit 2 negates the base test in bits 1..0
  localparam br_func_t BR_LBC = 3'b000;
  localparam br_func_t BR_EQ  = 3'b001;
  localparam br_func_t BR_LT  = 3'b010;
  localparam br_func_t BR_LE  = 3'b011;
  localparam br_func_t BR_LBS = 3'b100;
  localparam br_func_t BR_NE  = 3'b101;
  localparam br_func_t BR_GE  = 3'b110;
  localparam br_func_t BR_GT  = 3'b111;

  // Marker word for an undefined ALU code
  localparam word_t ALU_ILLEGAL_RESULT = 64'hdeadbeef_baadbeef;

endpackage

// ==== design/ex_result_if.sv ====
// One result bus of the EX stage; no clock inside, valid is a plain one-cycle strobe per item
`timescale 1ns/1ps

interface ex_result_if;

  // Tag, program counter, destination and payload of one completed operation
  ex_pkg::inst_t    ir;
  ex_pkg::word_t    npc;
  ex_pkg::reg_idx_t dest_reg;
  ex_pkg::word_t    result;
  logic             valid;

  // Producer side, an execution path
  modport src (output ir, npc, dest_reg, result, valid);

  // Consumer side, the output arbiter
  modport dst (input ir, npc, dest_reg, result, valid);

endinterface

// ==== design/ex_stage.sv ====
// Two-lane EX stage; upstream holds its inputs while a lane stalls, only lane 1 resolves branches
`timescale 1ns/1ps

module ex_stage #(
  parameter int MULT_STAGES = 4
) (
  input  logic              clock,
  input  logic              reset,
  // Lane 1 issue
  input  logic              id_valid_1,
  input  logic              id_is_mult_1,
  input  logic              id_is_branch_1,
  input  ex_pkg::inst_t     id_ir_1,
  input  ex_pkg::word_t     id_npc_1,
  input  ex_pkg::reg_idx_t  id_dest_reg_1,
  input  ex_pkg::word_t     id_opa_1,
  input  ex_pkg::word_t     id_opb_1,
  input  ex_pkg::alu_func_t id_func_1,
  // Lane 2 issue
  input  logic              id_valid_2,
  input  logic              id_is_mult_2,
  input  ex_pkg::inst_t     id_ir_2,
  input  ex_pkg::word_t     id_npc_2,
  input  ex_pkg::reg_idx_t  id_dest_reg_2,
  input  ex_pkg::word_t     id_opa_2,
  input  ex_pkg::word_t     id_opb_2,
  input  ex_pkg::alu_func_t id_func_2,
  // Lane 1 result
  output ex_pkg::inst_t     ex_ir_1,
  output ex_pkg::word_t     ex_npc_1,
  output ex_pkg::reg_idx_t  ex_dest_reg_1,
  output ex_pkg::word_t     ex_result_1,
  output logic              ex_valid_1,
  output logic              ex_stall_1,
  output logic              ex_take_branch,
  // Lane 2 result
  output ex_pkg::inst_t     ex_ir_2,
  output ex_pkg::word_t     ex_npc_2,
  output ex_pkg::reg_idx_t  ex_dest_reg_2,
  output ex_pkg::word_t     ex_result_2,
  output logic              ex_valid_2,
  output logic              ex_stall_2
);

  ex_result_if int_bus_1 ();
  ex_result_if mult_bus_1 ();
  ex_result_if int_bus_2 ();
  ex_result_if mult_bus_2 ();

  // Lane 1, valid split by is_mult
  ex_int_lane #(.BRANCH_EN(1'b1)) int_lane_1 (
    .clock (clock), .reset (reset), .stall (ex_stall_1),
    .valid (id_valid_1 && !id_is_mult_1), .is_branch (id_is_branch_1),
    .ir (id_ir_1), .npc (id_npc_1), .dest_reg (id_dest_reg_1),
    .opa (id_opa_1), .opb (id_opb_1), .func (id_func_1),
    .take_branch (ex_take_branch), .out (int_bus_1)
  );

  ex_mult #(.MULT_STAGES(MULT_STAGES)) mult_1 (
    .clock (clock), .reset (reset), .stall (ex_stall_1),
    .valid (id_valid_1 && id_is_mult_1), .ir (id_ir_1), .npc (id_npc_1),
    .dest_reg (id_dest_reg_1), .opa (id_opa_1), .opb (id_opb_1), .out (mult_bus_1)
  );

  ex_arbiter arbiter_1 (
    .int_in (int_bus_1), .mult_in (mult_bus_1), .stall (ex_stall_1),
    .ir (ex_ir_1), .npc (ex_npc_1), .dest_reg (ex_dest_reg_1),
    .result (ex_result_1), .valid (ex_valid_1)
  );

  // Lane 2 has no branch logic
  ex_int_lane #(.BRANCH_EN(1'b0)) int_lane_2 (
    .clock (clock), .reset (reset), .stall (ex_stall_2),
    .valid (id_valid_2 && !id_is_mult_2), .is_branch (1'b0),
    .ir (id_ir_2), .npc (id_npc_2), .dest_reg (id_dest_reg_2),
    .opa (id_opa_2), .opb (id_opb_2), .func (id_func_2),
    .take_branch (), .out (int_bus_2)
  );

  ex_mult #(.MULT_STAGES(MULT_STAGES)) mult_2 (
    .clock (clock), .reset (reset), .stall (ex_stall_2),
    .valid (id_valid_2 && id_is_mult_2), .ir (id_ir_2), .npc (id_npc_2),
    .dest_reg (id_dest_reg_2), .opa (id_opa_2), .opb (id_opb_2), .out (mult_bus_2)
  );

  ex_arbiter arbiter_2 (
    .int_in (int_bus_2), .mult_in (mult_bus_2), .stall (ex_stall_2),
    .ir (ex_ir_2), .npc (ex_npc_2), .dest_reg (ex_dest_reg_2),
    .result (ex_result_2), .valid (ex_valid_2)
  );

endmodule

// ==== src.f ====
design/ex_pkg.sv
design/ex_result_if.sv
design/ex_alu.sv
design/ex_brcond.sv
design/ex_int_lane.sv
design/ex_mult_stage.sv
design/ex_mult.sv
design/ex_arbiter.sv
design/ex_stage.sv
test/tb_ex_stage.sv

// ==== test/tb_ex_stage.sv ====
// Issues one table row per cycle on one lane; MULT_STAGES here must match the DUT and divide 64
`timescale 1ns/1ps

module tb_ex_stage;

  localparam int MULT_STAGES  = 4;
  localparam int MAX_ROWS     = 64;
  localparam int RESET_CYCLES = 10;

  // Row kinds
  localparam int K_ALU = 0;
  localparam int K_BR  = 1;
  localparam int K_MUL = 2;

  // One operation with its expected outcome
  typedef struct packed {
    logic [1:0]        lane;
    logic [1:0]        kind;
    ex_pkg::alu_func_t func;
    ex_pkg::word_t     opa;
    ex_pkg::word_t     opb;
    ex_pkg::word_t     npc;
    ex_pkg::inst_t     ir;
    ex_pkg::reg_idx_t  dest;
    ex_pkg::word_t     result;
    logic              taken;
  } row_t;

  logic              clock;
  logic              reset;
  logic              id_valid_1, id_is_mult_1, id_is_branch_1;
  ex_pkg::inst_t     id_ir_1;
  ex_pkg::word_t     id_npc_1, id_opa_1, id_opb_1;
  ex_pkg::reg_idx_t  id_dest_reg_1;
  ex_pkg::alu_func_t id_func_1;
  logic              id_valid_2, id_is_mult_2;
  ex_pkg::inst_t     id_ir_2;
  ex_pkg::word_t     id_npc_2, id_opa_2, id_opb_2;
  ex_pkg::reg_idx_t  id_dest_reg_2;
  ex_pkg::alu_func_t id_func_2;
  ex_pkg::inst_t     ex_ir_1, ex_ir_2;
  ex_pkg::word_t     ex_npc_1, ex_result_1, ex_npc_2, ex_result_2;
  ex_pkg::reg_idx_t  ex_dest_reg_1, ex_dest_reg_2;
  logic              ex_valid_1, ex_stall_1, ex_take_branch, ex_valid_2, ex_stall_2;

  // Table and scoreboard state
  row_t        rows [MAX_ROWS];
  bit          issued [MAX_ROWS];
  bit          seen [MAX_ROWS];
  int          accept_cycle [MAX_ROWS];
  int          stall_base [MAX_ROWS];
  int          stall_cnt [1:2];
  int          num_rows = 0;
  int          next_row = 0;
  int          seen_count = 0;
  int          cycle = 0;
  int          limit;
  logic [31:0] lfsr;

  ex_stage #(.MULT_STAGES(MULT_STAGES)) UUT (.*);

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Cycle count, also the run limit
  always @(posedge clock)
  begin
    cycle <= cycle + 1;
    if (cycle >= limit)
      fail_run($sformatf("Timeout with operations still pending after %0d cycles", limit));
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
      fail_run($sformatf("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, want));
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_word(output ex_pkg::word_t w);
    int i;
    w = '0;
    for (i = 0; i < 64; i++)
    begin
      lfsr = lfsr_step(lfsr);
      w = {w[62:0], lfsr[0]};
    end
  endtask

  // Reference for the ALU codes used by random rows
  function automatic ex_pkg::word_t ref_alu(input ex_pkg::alu_func_t f,
                                            input ex_pkg::word_t a, input ex_pkg::word_t b);
    logic [127:0]  ext;
    ex_pkg::word_t r;
    ext = {{64{a[63]}}, a} >> b[5:0];
    r = ex_pkg::ALU_ILLEGAL_RESULT;
    case (f)
      ex_pkg::ALU_ADDQ:   r = a + b;
      ex_pkg::ALU_SUBQ:   r = a + ~b + 64'd1;
      ex_pkg::ALU_XOR:    r = (a | b) & ~(a & b);
      ex_pkg::ALU_SRA:    r = ext[63:0];
      ex_pkg::ALU_CMPLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ex_pkg::ALU_CMPULE: r = (b < a) ? 64'd0 : 64'd1;
      default:            r = ex_pkg::ALU_ILLEGAL_RESULT;
    endcase
    return r;
  endfunction

  // Tag and destination come from the row number
  task automatic add_row(input int lane, input int kind, input ex_pkg::alu_func_t func,
                         input ex_pkg::word_t opa, input ex_pkg::word_t opb,
                         input ex_pkg::word_t npc, input ex_pkg::word_t result,
                         input logic taken);
    rows[num_rows].lane   = 2'(lane);
    rows[num_rows].kind   = 2'(kind);
    rows[num_rows].func   = func;
    rows[num_rows].opa    = opa;
    rows[num_rows].opb    = opb;
    rows[num_rows].npc    = npc;
    rows[num_rows].ir     = 32'hc0de0000 + num_rows;
    rows[num_rows].dest   = ex_pkg::reg_idx_t'(num_rows);
    rows[num_rows].result = result;
    rows[num_rows].taken  = taken;
    num_rows++;
  endtask

  task automatic add_alu(input int lane, input ex_pkg::alu_func_t func,
                         input ex_pkg::word_t opa, input ex_pkg::word_t opb,
                         input ex_pkg::word_t result);
    add_row(lane, K_ALU, func, opa, opb, 64'h10000 + 4 * num_rows, result, 1'b0);
  endtask

  // Taken branches return npc plus the displacement
  task automatic add_branch(input ex_pkg::br_func_t f, input ex_pkg::word_t opa,
                            input ex_pkg::word_t opb, input ex_pkg::word_t npc, input logic taken);
    add_row(1, K_BR, {2'b00, f}, opa, opb, npc, taken ? npc + opb : npc, taken);
  endtask

  task automatic add_mult(input int lane, input ex_pkg::word_t opa, input ex_pkg::word_t opb,
                          input ex_pkg::word_t result);
    add_row(lane, K_MUL, ex_pkg::ALU_ADDQ, opa, opb, 64'h10000 + 4 * num_rows, result, 1'b0);
  endtask

  task automatic add_random(input int lane, input int kind, input ex_pkg::alu_func_t func);
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    random_word(a);
    random_word(b);
    add_row(lane, kind, func, a, b, 64'h10000 + 4 * num_rows,
            (kind == K_MUL) ? a * b : ref_alu(func, a, b), 1'b0);
  endtask

  task automatic build_table();
    // Logic ops on one operand pair
    add_alu(1, ex_pkg::ALU_ADDQ, 64'hffffffffffffffff, 64'h2, 64'h1);
    add_alu(1, ex_pkg::ALU_SUBQ, 64'h3, 64'h5, 64'hfffffffffffffffe);
    add_alu(1, ex_pkg::ALU_AND, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf000f000f000f000);
    add_alu(1, ex_pkg::ALU_BIC, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h00f000f000f000f0);
    add_alu(1, ex_pkg::ALU_BIS, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hfff0fff0fff0fff0);
    add_alu(1, ex_pkg::ALU_ORNOT, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf0fff0fff0fff0ff);
    add_alu(1, ex_pkg::ALU_XOR, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h0ff00ff00ff00ff0);
    add_alu(1, ex_pkg::ALU_EQV, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf00ff00ff00ff00f);
    add_alu(2, ex_pkg::ALU_SRL, 64'h8000000000000010, 64'h4, 64'h0800000000000001);
    add_alu(2, ex_pkg::ALU_SLL, 64'h8000000000000010, 64'h4, 64'h0000000000000100);
    add_alu(2, ex_pkg::ALU_SRA, 64'h8000000000000010, 64'h4, 64'hf800000000000001);
    // Back-to-back multiplies, then branches that collide with them
    add_mult(1, 64'h3, 64'h5, 64'hf);
    add_mult(1, 64'hffffffffffffffff, 64'h2, 64'hfffffffffffffffe);
    add_branch(ex_pkg::BR_LBC, 64'h2, 64'h40, 64'h2000, 1'b1);
    add_branch(ex_pkg::BR_EQ, 64'h5, 64'h40, 64'h2004, 1'b0);
    add_branch(ex_pkg::BR_LT, 64'hffffffffffffffff, 64'hfffffffffffffff0, 64'h2008, 1'b1);
    add_branch(ex_pkg::BR_LE, 64'h7, 64'h40, 64'h200c, 1'b0);
    add_branch(ex_pkg::BR_LBS, 64'h3, 64'h80, 64'h2010, 1'b1);
    add_branch(ex_pkg::BR_NE, 64'h0, 64'h80, 64'h2014, 1'b0);
    add_branch(ex_pkg::BR_GE, 64'h10, 64'h80, 64'h2018, 1'b1);
    add_branch(ex_pkg::BR_GT, 64'h0, 64'h80, 64'h201c, 1'b0);
    add_branch(ex_pkg::BR_LE, 64'h0, 64'h40, 64'h2020, 1'b1);
    add_branch(ex_pkg::BR_GT, 64'h9, 64'h40, 64'h2024, 1'b1);
    // Lane 2 multiplies, then compares that wait behind them
    add_mult(2, 64'h100000000, 64'h100000000, 64'h0);
    add_mult(2, 64'h12345678, 64'h10, 64'h123456780);
    add_alu(2, ex_pkg::ALU_CMPULT, 64'h1, 64'hffffffffffffffff, 64'h1);
    add_alu(2, ex_pkg::ALU_CMPULT, 64'hffffffffffffffff, 64'h1, 64'h0);
    add_alu(2, ex_pkg::ALU_CMPEQ, 64'h1234, 64'h1234, 64'h1);
    add_alu(2, ex_pkg::ALU_CMPULE, 64'h5, 64'h5, 64'h1);
    add_alu(2, ex_pkg::ALU_CMPLT, 64'hffffffffffffffff, 64'h1, 64'h1);
    add_alu(2, ex_pkg::ALU_CMPLE, 64'h1, 64'hffffffffffffffff, 64'h0);
    add_alu(2, 5'h0b, 64'h1, 64'h2, ex_pkg::ALU_ILLEGAL_RESULT);
    add_alu(1, 5'h1f, 64'h1, 64'h2, ex_pkg::ALU_ILLEGAL_RESULT);
    // Random operands
    add_random(1, K_MUL, ex_pkg::ALU_ADDQ);
    add_random(1, K_MUL, ex_pkg::ALU_ADDQ);
    add_random(2, K_ALU, ex_pkg::ALU_ADDQ);
    add_random(2, K_MUL, ex_pkg::ALU_ADDQ);
    add_random(1, K_ALU, ex_pkg::ALU_SUBQ);
    add_random(2, K_ALU, ex_pkg::ALU_SRA);
    add_random(1, K_ALU, ex_pkg::ALU_CMPLT);
    add_random(2, K_ALU, ex_pkg::ALU_CMPULE);
    add_random(1, K_ALU, ex_pkg::ALU_XOR);
  endtask

  task automatic idle_lanes();
    id_valid_1     = 1'b0;
    id_is_mult_1   = 1'b0;
    id_is_branch_1 = 1'b0;
    id_valid_2     = 1'b0;
    id_is_mult_2   = 1'b0;
  endtask

  // Valid, stall and take_branch all low
  task automatic check_quiet();
    check_value("ex_valid_1", ex_valid_1, 1'b0);
    check_value("ex_valid_2", ex_valid_2, 1'b0);
    check_value("ex_stall_1", ex_stall_1, 1'b0);
    check_value("ex_stall_2", ex_stall_2, 1'b0);
    check_value("ex_take_branch", ex_take_branch, 1'b0);
  endtask

  task automatic present_row(input int k);
    if (rows[k].lane == 1)
    begin
      id_valid_1     = 1'b1;
      id_is_mult_1   = rows[k].kind == K_MUL;
      id_is_branch_1 = rows[k].kind == K_BR;
      {id_ir_1, id_npc_1, id_dest_reg_1} = {rows[k].ir, rows[k].npc, rows[k].dest};
      {id_opa_1, id_opb_1, id_func_1}    = {rows[k].opa, rows[k].opb, rows[k].func};
    end
    else
    begin
      id_valid_2   = 1'b1;
      id_is_mult_2 = rows[k].kind == K_MUL;
      {id_ir_2, id_npc_2, id_dest_reg_2} = {rows[k].ir, rows[k].npc, rows[k].dest};
      {id_opa_2, id_opb_2, id_func_2}    = {rows[k].opa, rows[k].opb, rows[k].func};
    end
  endtask

  // Present the next row, held while its lane stalls
  task automatic drive_next();
    logic busy;
    idle_lanes();
    if (next_row < num_rows)
    begin
      present_row(next_row);
      busy = (rows[next_row].lane == 1) ? ex_stall_1 : ex_stall_2;
      if (!busy)
      begin
        issued[next_row]       = 1'b1;
        accept_cycle[next_row] = cycle;
        stall_base[next_row]   = stall_cnt[rows[next_row].lane];
        next_row++;
      end
    end
  endtask

  // Match one lane output against pending rows by tag
  task automatic check_lane(input int lane, input logic valid, input logic stall,
                            input logic take, input ex_pkg::inst_t tag,
                            input ex_pkg::word_t npc, input ex_pkg::reg_idx_t dest,
                            input ex_pkg::word_t result);
    int hit;
    int k;
    int lat;
    hit = -1;
    if (!valid)
    begin
      check_value($sformatf("ex_stall_%0d", lane), stall, 1'b0);
      if (lane == 1)
        check_value("ex_take_branch", take, 1'b0);
    end
    else
    begin
      for (k = 0; k < num_rows; k++)
        if (issued[k] && !seen[k] && rows[k].lane == lane && rows[k].ir == tag)
          hit = k;
      if (hit < 0)
        fail_run($sformatf("Lane %0d delivered tag %h with no pending operation", lane, tag));
      else
      begin
        seen[hit] = 1'b1;
        seen_count++;
        // Integer results slip by one cycle per stalled cycle
        lat = (rows[hit].kind == K_MUL) ? MULT_STAGES
                                        : 1 + stall_cnt[lane] - stall_base[hit];
        check_value($sformatf("ex_result_%0d", lane), result, rows[hit].result);
        check_value($sformatf("ex_npc_%0d", lane), npc, rows[hit].npc);
        check_value($sformatf("ex_dest_reg_%0d", lane), dest, rows[hit].dest);
        check_value($sformatf("ex_stall_%0d", lane), stall, rows[hit].kind == K_MUL);
        if (lane == 1)
          check_value("ex_take_branch", take, rows[hit].kind == K_BR && rows[hit].taken);
        check_value($sformatf("latency of tag %h", tag), cycle - accept_cycle[hit], lat);
      end
    end
  endtask

  task automatic observe_outputs();
    check_lane(1, ex_valid_1, ex_stall_1, ex_take_branch, ex_ir_1, ex_npc_1,
               ex_dest_reg_1, ex_result_1);
    check_lane(2, ex_valid_2, ex_stall_2, 1'b0, ex_ir_2, ex_npc_2, ex_dest_reg_2, ex_result_2);
  endtask

  initial
  begin
    reset = 1'b1;
    idle_lanes();
    {id_ir_1, id_npc_1, id_dest_reg_1, id_opa_1, id_opb_1, id_func_1} = '0;
    {id_ir_2, id_npc_2, id_dest_reg_2, id_opa_2, id_opb_2, id_func_2} = '0;
    stall_cnt[1] = 0;
    stall_cnt[2] = 0;
    lfsr = 32'hdc8c5080;
    build_table();
    limit = 20 + num_rows * (MULT_STAGES + 3);
    // Taken branch on lane 1 and a multiply on lane 2, both held off by reset
    id_valid_1     = 1'b1;
    id_is_branch_1 = 1'b1;
    id_valid_2     = 1'b1;
    id_is_mult_2   = 1'b1;
    repeat (RESET_CYCLES)
    begin
      @(negedge clock);
      check_quiet();
    end
    reset = 1'b0;
    idle_lanes();
    @(negedge clock);
    // Quiet outputs before the first issue
    check_quiet();
    while (seen_count < num_rows)
    begin
      observe_outputs();
      if (ex_stall_1)
        stall_cnt[1]++;
      if (ex_stall_2)
        stall_cnt[2]++;
      drive_next();
      @(negedge clock);
    end
    // Nothing more may come out once every tag is in
    repeat (MULT_STAGES + 2)
    begin
      observe_outputs();
      @(negedge clock);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
